/* design/rename_defines.svh */
// rename stage configuration
// widths and register counts shared by the package and every rename block

`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// ====================
// machine width
// ====================
`define RN_DECODE_WIDTH 2   // instructions renamed per cycle
`define RN_WB_WIDTH     2   // writeback ports
`define RN_COMMIT_WIDTH 2   // commit ports

// ====================
// register counts
// ====================
`define RN_PHY_REG_NUM  64  // physical registers, one alias table entry each
`define RN_ARCH_REG_NUM 32  // architectural registers

// index widths, follow the counts above
`define RN_PREG_W $clog2(`RN_PHY_REG_NUM)
`define RN_AREG_W $clog2(`RN_ARCH_REG_NUM)

`endif // RENAME_DEFINES_SVH

/* design/rename_pkg.sv */
// rename stage types
// register index types and the request, response, writeback and commit
// records passed between the rename blocks

`default_nettype none

`include "rename_defines.svh"

package rename_pkg;

  typedef logic [`RN_PREG_W-1:0] preg_t;  // physical reg index
  typedef logic [`RN_AREG_W-1:0] areg_t;  // architectural reg index

  typedef logic [`RN_PHY_REG_NUM-1:0] phy_vec_t;  // one bit per preg

  // one instruction: dest = src0 op src1
  typedef struct packed {
    logic  dest_valid;  // instruction writes a dest
    areg_t src0;
    areg_t src1;
    areg_t dest;
  } rename_req_t;

  // one renamed instruction
  typedef struct packed {
    preg_t psrc0;
    logic  psrc0_ready;
    preg_t psrc1;
    logic  psrc1_ready;
    preg_t pdst;         // newly allocated preg
    preg_t ppdst;        // previous mapping of dest
    logic  ppdst_valid;
  } rename_rsp_t;

  typedef struct packed {
    logic  valid;
    preg_t pdest;  // preg whose value is now written
  } wb_t;

  typedef struct packed {
    logic  valid;
    preg_t preg;      // mapping that becomes architectural
    preg_t old_preg;  // mapping it replaces
    logic  old_valid;
  } commit_t;

endpackage : rename_pkg

`default_nettype wire

/* design/register_alias_table.sv */
// register alias table
// CAM style map, one entry per physical register holding an arch tag,
// a valid bit and a ready bit. looks up sources and the old dest mapping
// for each slot, bypasses same-group RAW/WAW, writes new mappings when
// enabled, marks writebacks ready and rebuilds from the committed vector

`default_nettype none

`include "rename_defines.svh"

module register_alias_table
  import rename_pkg::*;
(
  input  wire logic                                    clk,
  input  wire logic                                    rst_n,
  input  wire logic                                    restore_i,       // flush, rebuild map
  input  wire phy_vec_t                                commit_valid_i,  // committed valid bits
  input  wire logic                                    rename_en_i,     // grant from free list
  input  wire logic        [`RN_DECODE_WIDTH-1:0]      rename_valid_i,
  input  wire rename_req_t [`RN_DECODE_WIDTH-1:0]      rename_req_i,
  input  wire preg_t       [`RN_DECODE_WIDTH-1:0]      alloc_preg_i,    // new pdst per slot
  input  wire wb_t         [`RN_WB_WIDTH-1:0]          wb_i,
  output rename_rsp_t      [`RN_DECODE_WIDTH-1:0]      rename_rsp_o
);

  localparam int unsigned N = `RN_PHY_REG_NUM;
  localparam int unsigned A = `RN_ARCH_REG_NUM;

  // ====================
  // table state
  // ====================
  areg_t    [N-1:0] arch_tag_q, arch_tag_d;  // arch reg held by each preg
  phy_vec_t         valid_q, valid_d;        // entry is the live mapping
  phy_vec_t         ready_q, ready_d;        // value written back

  logic [`RN_DECODE_WIDTH-1:0] slot_wr;  // slot writes a dest this group

  always_comb begin
    for (int i = 0; i < `RN_DECODE_WIDTH; i++) begin
      slot_wr[i] = rename_valid_i[i] & rename_req_i[i].dest_valid;
    end
  end

  // ====================
  // lookup
  // ====================
  always_comb begin
    for (int i = 0; i < `RN_DECODE_WIDTH; i++) begin
      rename_rsp_o[i].psrc0       = '0;
      rename_rsp_o[i].psrc0_ready = 1'b1;
      rename_rsp_o[i].psrc1       = '0;
      rename_rsp_o[i].psrc1_ready = 1'b1;
      rename_rsp_o[i].pdst        = alloc_preg_i[i];  // straight from free list
      rename_rsp_o[i].ppdst       = '0;
      rename_rsp_o[i].ppdst_valid = 1'b0;

      // cam search, at most one valid hit per tag
      for (int j = 0; j < N; j++) begin
        if (valid_q[j] && arch_tag_q[j] == rename_req_i[i].src0) begin
          rename_rsp_o[i].psrc0       = preg_t'(j);
          rename_rsp_o[i].psrc0_ready = ready_q[j];  // old ready, wb lands next edge
        end
        if (valid_q[j] && arch_tag_q[j] == rename_req_i[i].src1) begin
          rename_rsp_o[i].psrc1       = preg_t'(j);
          rename_rsp_o[i].psrc1_ready = ready_q[j];
        end
        if (valid_q[j] && arch_tag_q[j] == rename_req_i[i].dest) begin
          rename_rsp_o[i].ppdst       = preg_t'(j);
          rename_rsp_o[i].ppdst_valid = 1'b1;
        end
      end

      // same-group bypass, later slots win over the table
      for (int j = 0; j < i; j++) begin
        if (slot_wr[j]) begin
          if (rename_req_i[i].src0 == rename_req_i[j].dest) begin  // RAW
            rename_rsp_o[i].psrc0       = alloc_preg_i[j];
            rename_rsp_o[i].psrc0_ready = 1'b0;
          end
          if (rename_req_i[i].src1 == rename_req_i[j].dest) begin  // RAW
            rename_rsp_o[i].psrc1       = alloc_preg_i[j];
            rename_rsp_o[i].psrc1_ready = 1'b0;
          end
          if (rename_req_i[i].dest == rename_req_i[j].dest) begin  // WAW
            rename_rsp_o[i].ppdst       = alloc_preg_i[j];
            rename_rsp_o[i].ppdst_valid = 1'b1;
          end
        end
      end
    end
  end

  // ====================
  // update
  // ====================
  always_comb begin
    arch_tag_d = arch_tag_q;
    valid_d    = valid_q;
    ready_d    = ready_q;

    if (restore_i) begin
      // pipeline is empty after a flush, so everything left is ready
      valid_d = commit_valid_i;
      ready_d = '1;
    end else begin
      // slot order matters, slot 1 may retire slot 0's new entry
      for (int i = 0; i < `RN_DECODE_WIDTH; i++) begin
        if (rename_en_i && slot_wr[i]) begin
          arch_tag_d[alloc_preg_i[i]] = rename_req_i[i].dest;
          valid_d[alloc_preg_i[i]]    = 1'b1;
          ready_d[alloc_preg_i[i]]    = 1'b0;  // pending writeback
          if (rename_rsp_o[i].ppdst_valid) begin
            valid_d[rename_rsp_o[i].ppdst] = 1'b0;  // old mapping no longer live
          end
        end
      end

      for (int k = 0; k < `RN_WB_WIDTH; k++) begin
        if (wb_i[k].valid) begin
          ready_d[wb_i[k].pdest] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // identity map for the arch regs, rest idle
      for (int j = 0; j < N; j++) begin
        arch_tag_q[j] <= areg_t'(j % A);
        valid_q[j]    <= (j < A);
      end
      ready_q <= '1;
    end else begin
      arch_tag_q <= arch_tag_d;
      valid_q    <= valid_d;
      ready_q    <= ready_d;
    end
  end

endmodule : register_alias_table

`default_nettype wire

/* design/free_list.sv */
// free list
// bitmap of unmapped physical registers. grants a rename group only when
// enough registers are free for every slot with a dest, handing out the
// lowest free indices in slot order. commits return old registers and a
// restore reloads the bitmap from the inverse of the committed vector

`default_nettype none

`include "rename_defines.svh"

module free_list
  import rename_pkg::*;
(
  input  wire logic                                clk,
  input  wire logic                                rst_n,
  input  wire logic                                restore_i,
  input  wire phy_vec_t                            commit_valid_i,  // committed map
  input  wire logic        [`RN_DECODE_WIDTH-1:0]  rename_valid_i,
  input  wire rename_req_t [`RN_DECODE_WIDTH-1:0]  rename_req_i,
  input  wire commit_t     [`RN_COMMIT_WIDTH-1:0]  commit_i,
  output logic                                     grant_o,         // whole group fits
  output preg_t            [`RN_DECODE_WIDTH-1:0]  alloc_preg_o
);

  localparam int unsigned N     = `RN_PHY_REG_NUM;
  localparam int unsigned CNT_W = $clog2(N) + 1;  // counts up to N

  phy_vec_t free_q, free_d;  // 1 = preg free

  logic [`RN_DECODE_WIDTH-1:0] need;  // slot asks for a preg
  logic [CNT_W-1:0]            need_cnt;
  logic [CNT_W-1:0]            free_cnt;
  phy_vec_t                    avail;  // free bits left after earlier slots

  // ====================
  // count and grant
  // ====================
  always_comb begin
    need_cnt = '0;
    for (int i = 0; i < `RN_DECODE_WIDTH; i++) begin
      need[i]  = rename_valid_i[i] & rename_req_i[i].dest_valid;
      need_cnt = need_cnt + CNT_W'(need[i]);
    end
    free_cnt = '0;
    for (int j = 0; j < N; j++) begin
      free_cnt = free_cnt + CNT_W'(free_q[j]);
    end
    grant_o = (free_cnt >= need_cnt) && !restore_i;  // all or nothing
  end

  // lowest free preg to lowest needing slot, and so on
  always_comb begin
    avail = free_q;
    for (int i = 0; i < `RN_DECODE_WIDTH; i++) begin
      alloc_preg_o[i] = '0;
      if (need[i]) begin
        for (int j = N - 1; j >= 0; j--) begin
          if (avail[j]) alloc_preg_o[i] = preg_t'(j);  // last hit is lowest
        end
        avail[alloc_preg_o[i]] = 1'b0;  // taken, hide from later slots
      end
    end
  end

  // ====================
  // next state
  // ====================
  always_comb begin
    free_d = free_q;
    if (restore_i) begin
      free_d = ~commit_valid_i;  // whatever is not architectural is free
    end else begin
      if (grant_o) free_d = avail;  // drop allocated pregs
      for (int k = 0; k < `RN_COMMIT_WIDTH; k++) begin
        if (commit_i[k].valid && commit_i[k].old_valid) begin
          free_d[commit_i[k].old_preg] = 1'b1;  // usable next cycle
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int j = 0; j < N; j++) begin
        free_q[j] <= (j >= `RN_ARCH_REG_NUM);  // low pregs hold the arch regs
      end
    end else begin
      free_q <= free_d;
    end
  end

endmodule : free_list

`default_nettype wire

/* design/commit_map.sv */
// committed map
// architectural valid vector, one bit per physical register. each commit
// makes its new preg architectural and drops the one it replaced. the
// vector steers the alias table and the free list when a flush restores them

`default_nettype none

`include "rename_defines.svh"

module commit_map
  import rename_pkg::*;
(
  input  wire logic                                clk,
  input  wire logic                                rst_n,
  input  wire commit_t     [`RN_COMMIT_WIDTH-1:0]  commit_i,
  output phy_vec_t                                 commit_valid_o  // registered
);

  // ====================
  // committed state
  // ====================
  phy_vec_t commit_valid_q;
  phy_vec_t commit_valid_d;

  // slot order, a later commit may retire an earlier one's preg
  always_comb begin
    commit_valid_d = commit_valid_q;
    for (int k = 0; k < `RN_COMMIT_WIDTH; k++) begin
      if (commit_i[k].valid) begin
        commit_valid_d[commit_i[k].preg] = 1'b1;
        if (commit_i[k].old_valid) begin
          commit_valid_d[commit_i[k].old_preg] = 1'b0;  // replaced mapping
        end
      end
    end
  end

  // applies commits even on a restore cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int j = 0; j < `RN_PHY_REG_NUM; j++) begin
        commit_valid_q[j] <= (j < `RN_ARCH_REG_NUM);  // identity map
      end
    end else begin
      commit_valid_q <= commit_valid_d;
    end
  end

  assign commit_valid_o = commit_valid_q;

endmodule : commit_map

`default_nettype wire

/* design/rename_top.sv */
// register rename stage
// joins the alias table, the free list and the committed map. the free
// list's grant is the group-level ok and the table's write enable

`default_nettype none

`include "rename_defines.svh"

module rename_top
  import rename_pkg::*;
(
  input  wire logic                                clk,
  input  wire logic                                rst_n,
  input  wire logic                                restore_i,
  input  wire logic        [`RN_DECODE_WIDTH-1:0]  rename_valid_i,
  input  wire rename_req_t [`RN_DECODE_WIDTH-1:0]  rename_req_i,
  input  wire wb_t         [`RN_WB_WIDTH-1:0]      wb_i,
  input  wire commit_t     [`RN_COMMIT_WIDTH-1:0]  commit_i,
  output logic                                     rename_ok_o,   // low means retry group
  output rename_rsp_t      [`RN_DECODE_WIDTH-1:0]  rename_rsp_o
);

  logic                          grant;
  preg_t [`RN_DECODE_WIDTH-1:0]  alloc_preg;
  phy_vec_t                      commit_valid;

  // ====================
  // blocks
  // ====================
  commit_map commit_map_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .commit_i       (commit_i),
    .commit_valid_o (commit_valid)
  );

  free_list free_list_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .restore_i      (restore_i),
    .commit_valid_i (commit_valid),
    .rename_valid_i (rename_valid_i),
    .rename_req_i   (rename_req_i),
    .commit_i       (commit_i),
    .grant_o        (grant),
    .alloc_preg_o   (alloc_preg)
  );

  register_alias_table register_alias_table_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .restore_i      (restore_i),
    .commit_valid_i (commit_valid),
    .rename_en_i    (grant),        // table gates it per slot
    .rename_valid_i (rename_valid_i),
    .rename_req_i   (rename_req_i),
    .alloc_preg_i   (alloc_preg),
    .wb_i           (wb_i),
    .rename_rsp_o   (rename_rsp_o)
  );

  assign rename_ok_o = grant;  // already low on restore

endmodule : rename_top

`default_nettype wire

/* verif/rename_model.svh */
// rename reference model
// speculative and committed arch maps, ready bits, free set, committed
// vector and the in-order list of renamed instructions still to commit

`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

typedef struct packed {
  areg_t arch;      // dest arch reg
  preg_t preg;      // new mapping
  preg_t old_preg;  // mapping it replaced
} pend_t;

preg_t    m_map  [`RN_ARCH_REG_NUM];  // speculative arch -> preg
preg_t    m_cmap [`RN_ARCH_REG_NUM];  // committed arch -> preg
phy_vec_t m_ready;
phy_vec_t m_free;
phy_vec_t m_commit;
pend_t    m_pend [$];                 // oldest first

task automatic model_reset();
  for (int r = 0; r < `RN_ARCH_REG_NUM; r++) begin
    m_map[r]  = preg_t'(r);  // identity map
    m_cmap[r] = preg_t'(r);
  end
  for (int j = 0; j < `RN_PHY_REG_NUM; j++) begin
    m_commit[j] = (j < `RN_ARCH_REG_NUM);
  end
  m_ready = '1;
  m_free  = ~m_commit;
  m_pend.delete();
endtask

// expected grant and responses of one group, from the current state
task automatic model_expect(input logic [`RN_DECODE_WIDTH-1:0] v,
                            input rename_req_t [`RN_DECODE_WIDTH-1:0] req, input logic rs,
                            output logic ok, output rename_rsp_t [`RN_DECODE_WIDTH-1:0] rsp,
                            output logic [`RN_DECODE_WIDTH-1:0] need);
  phy_vec_t avail;
  int       n_need;
  avail  = m_free;
  n_need = 0;
  for (int i = 0; i < `RN_DECODE_WIDTH; i++) begin
    need[i] = v[i] & req[i].dest_valid;
    n_need += int'(need[i]);
  end
  ok = !rs && ($countones(m_free) >= n_need);  // whole group or nothing
  for (int i = 0; i < `RN_DECODE_WIDTH; i++) begin
    rsp[i] = '0;
    if (need[i]) begin
      for (int j = 0; j < `RN_PHY_REG_NUM; j++) begin
        if (avail[j]) begin  // lowest free index
          rsp[i].pdst = preg_t'(j);
          avail[j]    = 1'b0;
          break;
        end
      end
    end
    rsp[i].psrc0       = m_map[req[i].src0];
    rsp[i].psrc0_ready = m_ready[rsp[i].psrc0];
    rsp[i].psrc1       = m_map[req[i].src1];
    rsp[i].psrc1_ready = m_ready[rsp[i].psrc1];
    rsp[i].ppdst       = m_map[req[i].dest];
    rsp[i].ppdst_valid = 1'b1;  // every arch reg always mapped
    for (int j = 0; j < i; j++) begin
      if (need[j]) begin
        if (req[j].dest == req[i].src0) begin
          rsp[i].psrc0       = rsp[j].pdst;
          rsp[i].psrc0_ready = 1'b0;
        end
        if (req[j].dest == req[i].src1) begin
          rsp[i].psrc1       = rsp[j].pdst;
          rsp[i].psrc1_ready = 1'b0;
        end
        if (req[j].dest == req[i].dest) rsp[i].ppdst = rsp[j].pdst;
      end
    end
  end
endtask

// state after the clock edge
task automatic model_step(input logic rs, input logic ok,
                          input logic [`RN_DECODE_WIDTH-1:0] need,
                          input rename_req_t [`RN_DECODE_WIDTH-1:0] req,
                          input rename_rsp_t [`RN_DECODE_WIDTH-1:0] rsp,
                          input wb_t [`RN_WB_WIDTH-1:0] wbs,
                          input commit_t [`RN_COMMIT_WIDTH-1:0] cms);
  phy_vec_t old_commit;
  preg_t    old_cmap [`RN_ARCH_REG_NUM];
  pend_t    e;
  old_commit = m_commit;
  old_cmap   = m_cmap;
  for (int k = 0; k < `RN_COMMIT_WIDTH; k++) begin
    if (cms[k].valid) begin
      e = m_pend.pop_front();
      m_commit[e.preg]     = 1'b1;
      m_commit[e.old_preg] = 1'b0;
      m_cmap[e.arch]       = e.preg;
      if (!rs) m_free[e.old_preg] = 1'b1;
    end
  end
  if (rs) begin
    m_map   = old_cmap;  // flush back to committed state
    m_ready = '1;
    m_free  = ~old_commit;
    m_pend.delete();
  end else begin
    for (int i = 0; i < `RN_DECODE_WIDTH; i++) begin
      if (ok && need[i]) begin
        m_map[req[i].dest]   = rsp[i].pdst;
        m_ready[rsp[i].pdst] = 1'b0;
        m_free[rsp[i].pdst]  = 1'b0;
        e.arch     = req[i].dest;
        e.preg     = rsp[i].pdst;
        e.old_preg = rsp[i].ppdst;
        m_pend.push_back(e);
      end
    end
    for (int k = 0; k < `RN_WB_WIDTH; k++) begin
      if (wbs[k].valid) m_ready[wbs[k].pdest] = 1'b1;
    end
  end
endtask

`endif // RENAME_MODEL_SVH

/* verif/rename_tb.sv */
// rename stage testbench
// directed lookup, bypass, writeback, exhaustion and restore tests, then
// a long random mix, every cycle compared with the reference model

`default_nettype none

`include "rename_defines.svh"

module rename_tb
  import rename_pkg::*;
();

  localparam int W           = `RN_DECODE_WIDTH;
  localparam int CYC_RESET   = 3;
  localparam int CYC_LOOKUP  = `RN_ARCH_REG_NUM / 2;
  localparam int CYC_EXHAUST = 40;  // upper bound
  localparam int CYC_RESTORE = 60;
  localparam int CYC_RANDOM  = 2000;
  localparam int CYC_TOTAL   = CYC_RESET + CYC_LOOKUP + 2 + 3 + CYC_EXHAUST + CYC_RESTORE
                               + CYC_RANDOM;

  logic                             clk = 1'b0;
  logic                             rst_n;
  logic                             restore;
  logic        [W-1:0]              rename_valid;
  rename_req_t [W-1:0]              rename_req;
  wb_t         [`RN_WB_WIDTH-1:0]     wb;
  commit_t     [`RN_COMMIT_WIDTH-1:0] commit;
  logic                             rename_ok;
  rename_rsp_t [W-1:0]              rename_rsp;

  // stimulus for the next cycle
  logic                             nxt_restore;
  logic        [W-1:0]              nxt_valid;
  rename_req_t [W-1:0]              nxt_req;
  wb_t         [`RN_WB_WIDTH-1:0]     nxt_wb;
  commit_t     [`RN_COMMIT_WIDTH-1:0] nxt_commit;

  integer seed = 32'hd9f4_7ec7;
  int     n_tests, n_checks, n_errors, t_errors;
  int     guard;

  `include "rename_model.svh"

  rename_top rename_top_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .restore_i      (restore),
    .rename_valid_i (rename_valid),
    .rename_req_i   (rename_req),
    .wb_i           (wb),
    .commit_i       (commit),
    .rename_ok_o    (rename_ok),
    .rename_rsp_o   (rename_rsp)
  );

  always #50 clk = ~clk;

  // ====================
  // checks
  // ====================
  task automatic check_ok(input string name, input logic exp, input logic act);
    n_checks++;
    if (act !== exp) begin
      $display("error %s: rename_ok expected %b actual %b", name, exp, act);
      n_errors++;
      t_errors++;
    end
  endtask

  task automatic check_rsp(input string name, input rename_rsp_t exp, input rename_rsp_t act);
    n_checks++;
    if (act !== exp) begin
      $display("error %s: rsp expected %h actual %h", name, exp, act);
      n_errors++;
      t_errors++;
    end
  endtask

  task automatic end_test(input string name);
    $display("test %s finished with %0d errors", name, t_errors);
    n_tests++;
    t_errors = 0;
  endtask

  // ====================
  // stimulus helpers
  // ====================
  task automatic clear_stim();
    nxt_restore = 1'b0;
    nxt_valid   = '0;
    nxt_req     = '0;
    nxt_wb      = '0;
    nxt_commit  = '0;
  endtask

  function automatic rename_req_t make_req(input logic dv, input int s0, input int s1,
                                           input int d);
    rename_req_t req;
    req.dest_valid = dv;
    req.src0       = areg_t'(s0);
    req.src1       = areg_t'(s1);
    req.dest       = areg_t'(d);
    return req;
  endfunction

  task automatic commit_oldest(input int n);
    for (int k = 0; k < `RN_COMMIT_WIDTH; k++) begin
      nxt_commit[k] = '0;
      if (k < n && k < m_pend.size()) begin  // in program order
        nxt_commit[k].valid     = 1'b1;
        nxt_commit[k].preg      = m_pend[k].preg;
        nxt_commit[k].old_preg  = m_pend[k].old_preg;
        nxt_commit[k].old_valid = 1'b1;
      end
    end
  endtask

  task automatic full_group();  // both slots write a dest
    nxt_valid = '1;
    for (int i = 0; i < W; i++) begin
      nxt_req[i]            = rename_req_t'($random(seed));
      nxt_req[i].dest_valid = 1'b1;
    end
  endtask

  task automatic rand_stim(input bit allow_restore);
    int idx;
    clear_stim();
    for (int i = 0; i < W; i++) begin
      nxt_valid[i] = 1'($random(seed));
      nxt_req[i]   = rename_req_t'($random(seed));
    end
    for (int k = 0; k < `RN_WB_WIDTH; k++) begin
      if (m_pend.size() > 0 && {$random(seed)} % 2 == 0) begin
        idx               = {$random(seed)} % m_pend.size();
        nxt_wb[k].valid   = 1'b1;
        nxt_wb[k].pdest   = m_pend[idx].preg;  // any in-flight dest
      end
    end
    commit_oldest({$random(seed)} % 3);
    if (allow_restore && {$random(seed)} % 40 == 0) begin
      nxt_restore = 1'b1;
      nxt_commit  = '0;  // no commit on a flush cycle
    end
  endtask

  // drive at the edge, check just before the next one, then advance the model
  task automatic apply_cycle(input string name);
    logic                ok_exp;
    logic        [W-1:0] need;
    rename_rsp_t [W-1:0] rsp_exp;
    rename_rsp_t         exp_i;
    rename_rsp_t         act_i;
    @(posedge clk);
    restore      <= nxt_restore;
    rename_valid <= nxt_valid;
    rename_req   <= nxt_req;
    wb           <= nxt_wb;
    commit       <= nxt_commit;
    #90;
    model_expect(nxt_valid, nxt_req, nxt_restore, ok_exp, rsp_exp, need);
    check_ok(name, ok_exp, rename_ok);
    for (int i = 0; i < W; i++) begin
      exp_i = rsp_exp[i];
      act_i = rename_rsp[i];
      if (!need[i]) begin  // no dest, pdst unused
        exp_i.pdst = '0;
        act_i.pdst = '0;
      end
      if (ok_exp && nxt_valid[i]) check_rsp(name, exp_i, act_i);
    end
    model_step(nxt_restore, ok_exp, need, nxt_req, rsp_exp, nxt_wb, nxt_commit);
  endtask

  task automatic lookup_all(input string name);  // every arch reg, no dest
    for (int r = 0; r < `RN_ARCH_REG_NUM; r += 2) begin
      clear_stim();
      nxt_valid  = '1;
      nxt_req[0] = make_req(1'b0, r, r + 1, r);
      nxt_req[1] = make_req(1'b0, r + 1, r, r + 1);
      apply_cycle(name);
    end
  endtask

  // ====================
  // tests
  // ====================
  initial begin
    rst_n        = 1'b0;
    restore      = 1'b0;
    rename_valid = '0;
    rename_req   = '0;
    wb           = '0;
    commit       = '0;
    n_tests      = 0;
    n_checks     = 0;
    n_errors     = 0;
    t_errors     = 0;
    clear_stim();
    model_reset();
    repeat (CYC_RESET) @(posedge clk);
    rst_n <= 1'b1;

    lookup_all("reset_lookup");
    end_test("reset_lookup");

    clear_stim();
    nxt_valid  = '1;
    nxt_req[0] = make_req(1'b1, 3, 4, 5);
    nxt_req[1] = make_req(1'b1, 5, 6, 5);    // RAW and WAW on r5
    apply_cycle("bypass");
    nxt_req[0] = make_req(1'b1, 7, 8, 9);
    nxt_req[1] = make_req(1'b1, 10, 9, 11);  // RAW on src1
    apply_cycle("bypass");
    end_test("bypass");

    clear_stim();
    nxt_valid  = 2'b01;
    nxt_req[0] = make_req(1'b1, 1, 2, 12);
    apply_cycle("writeback");
    nxt_req[0]      = make_req(1'b0, 12, 12, 12);
    nxt_wb[0].valid = 1'b1;
    nxt_wb[0].pdest = m_pend[m_pend.size() - 1].preg;
    apply_cycle("writeback");                 // same cycle, still not ready
    nxt_wb = '0;
    apply_cycle("writeback");                 // ready now
    end_test("writeback");

    guard = 0;
    while ($countones(m_free) >= W && guard < CYC_EXHAUST - 4) begin
      clear_stim();
      full_group();
      apply_cycle("exhaust");
      guard++;
    end
    apply_cycle("exhaust");                   // does not fit
    clear_stim();
    nxt_valid  = '1;
    nxt_req[0] = make_req(1'b0, 5, 9, 11);
    nxt_req[1] = make_req(1'b0, 12, 3, 0);
    apply_cycle("exhaust");                   // map untouched
    clear_stim();
    full_group();
    commit_oldest(2);
    apply_cycle("exhaust");                   // freed regs not yet usable
    nxt_commit = '0;
    apply_cycle("exhaust");
    end_test("exhaust");

    for (int c = 0; c < 20; c++) begin
      rand_stim(1'b0);
      apply_cycle("restore");
    end
    clear_stim();
    commit_oldest(1);
    apply_cycle("restore");
    clear_stim();
    full_group();
    nxt_restore = 1'b1;
    apply_cycle("restore");
    lookup_all("restore");
    clear_stim();
    full_group();
    apply_cycle("restore");                   // allocation from committed complement
    apply_cycle("restore");
    end_test("restore");

    for (int c = 0; c < CYC_RANDOM; c++) begin
      rand_stim(1'b1);
      apply_cycle("random_mix");
    end
    end_test("random_mix");

    $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(CYC_TOTAL * 100 + 1000);
    $display("run timed out after %0d cycles before all tests finished", CYC_TOTAL);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule : rename_tb

`default_nettype wire

/* compile.f */
+incdir+design
+incdir+verif
design/rename_pkg.sv
design/register_alias_table.sv
design/free_list.sv
design/commit_map.sv
design/rename_top.sv
verif/rename_tb.sv

/* run.sh */
#!/bin/sh
# build the rename stage testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module rename_tb -o rename_sim

out=$(./obj_dir/rename_sim)
echo "$out"
echo "$out" | grep -qx "TESTBENCH PASSED"
